// File: common/adapter_pkg.sv
package adapter_pkg;

  // ------------------------------
  // bus and line geometry
  // ------------------------------
  localparam int BEAT_WIDTH       = 64;
  localparam int BEATS_PER_LINE   = 4;
  localparam int LINE_OFFSET_BITS = 5;
  localparam int ADDR_WIDTH       = 32;
  localparam int ID_WIDTH         = 4;
  localparam int BEAT_IDX_WIDTH   = 2;
  localparam int STRB_WIDTH       = BEAT_WIDTH / 8;

  // ------------------------------
  // basic types
  // ------------------------------
  typedef logic [BEAT_WIDTH-1:0]     beat_t;
  typedef logic [STRB_WIDTH-1:0]     strb_t;
  typedef beat_t [BEATS_PER_LINE-1:0] line_t;
  typedef strb_t [BEATS_PER_LINE-1:0] line_strb_t;
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [ID_WIDTH-1:0]       id_t;
  typedef logic [BEAT_IDX_WIDTH-1:0] beat_idx_t;

  // index of the final beat in a line burst
  localparam beat_idx_t LAST_BEAT_IDX = beat_idx_t'(BEATS_PER_LINE - 1);
  // AxLEN for a full line is beats minus one
  localparam logic [7:0] LINE_BURST_LEN = 8'(BEATS_PER_LINE - 1);
  // AxSIZE for a full-width beat
  localparam logic [2:0] BEAT_AXI_SIZE = 3'($clog2(STRB_WIDTH));

  // ------------------------------
  // enums
  // ------------------------------
  typedef enum logic {
    REQ_SINGLE,
    REQ_LINE
  } req_kind_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_AW_W,
    WAIT_AW,
    WAIT_W,
    WAIT_B,
    WAIT_R,
    DONE_READ
  } ctrl_state_e;

  // ------------------------------
  // core side
  // ------------------------------
  typedef struct packed {
    req_kind_e  kind;
    logic       we;
    addr_t      addr;
    id_t        id;
    logic [2:0] size;
    line_t      wdata;
    line_strb_t be;
  } core_req_t;

  typedef struct packed {
    line_t rdata;
    id_t   id;
    logic  err;
  } core_rsp_t;

  // ------------------------------
  // bus channels
  // ------------------------------
  // shared by AR and AW
  typedef struct packed {
    addr_t      addr;
    id_t        id;
    logic [7:0] len;
    logic [2:0] size;
  } axi_ax_t;

  typedef struct packed {
    beat_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    beat_t     data;
    id_t       id;
    axi_resp_e resp;
    logic      last;
  } axi_r_t;

  typedef struct packed {
    id_t       id;
    axi_resp_e resp;
  } axi_b_t;

endpackage

// File: hdl/adapter_ctrl.sv
`timescale 1ns/100ps

module adapter_ctrl
  import adapter_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // core side
  input  logic      core_req_valid_i,
  input  core_req_t core_req_i,
  output logic      core_gnt_o,
  output logic      core_rsp_valid_o,
  output core_rsp_t core_rsp_o,
  // address channels and write response
  output logic      ar_valid_o,
  output axi_ax_t   ar_o,
  input  logic      ar_ready_i,
  output logic      aw_valid_o,
  output axi_ax_t   aw_o,
  input  logic      aw_ready_i,
  input  logic      b_valid_i,
  input  axi_b_t    b_i,
  output logic      b_ready_o,
  // write beat sender
  output logic      wr_start_o,
  input  logic      wr_done_i,
  // line fill buffer
  output logic      rd_start_o,
  output req_kind_e rd_kind_o,
  input  logic      rd_done_i,
  input  logic      rd_err_i,
  input  id_t       rd_id_i,
  input  line_t     line_i
);

  ctrl_state_e state_q, state_d;
  id_t         id_q;
  logic        id_load;
  axi_ax_t     ax;

  // ------------------------------
  // address phase payload
  // ------------------------------
  always_comb begin
    ax.addr = core_req_i.addr;
    ax.id   = core_req_i.id;
    ax.len  = 8'd0;
    ax.size = core_req_i.size;
    if (core_req_i.kind == REQ_LINE) begin
      // incrementing burst from the start of the line
      ax.addr[LINE_OFFSET_BITS-1:0] = '0;
      ax.len                        = LINE_BURST_LEN;
      ax.size                       = BEAT_AXI_SIZE;
    end
  end

  assign ar_o      = ax;
  assign aw_o      = ax;
  assign rd_kind_o = core_req_i.kind;

  // ------------------------------
  // request FSM
  // ------------------------------
  always_comb begin
    state_d          = state_q;
    core_gnt_o       = 1'b0;
    core_rsp_valid_o = 1'b0;
    ar_valid_o       = 1'b0;
    aw_valid_o       = 1'b0;
    b_ready_o        = 1'b0;
    wr_start_o       = 1'b0;
    rd_start_o       = 1'b0;
    id_load          = 1'b0;
    core_rsp_o.rdata = '0;
    core_rsp_o.id    = id_q;
    core_rsp_o.err   = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (core_req_valid_i) begin
          id_load = 1'b1;
          if (core_req_i.we) begin
            // W starts right away while AW may still stall
            aw_valid_o = 1'b1;
            wr_start_o = 1'b1;
            state_d    = aw_ready_i ? WAIT_W : WAIT_AW_W;
          end else begin
            ar_valid_o = 1'b1;
            if (ar_ready_i) begin
              core_gnt_o = 1'b1;
              rd_start_o = 1'b1;
              state_d    = WAIT_R;
            end
          end
        end
      end

      WAIT_AW_W: begin
        aw_valid_o = 1'b1;
        case ({aw_ready_i, wr_done_i})
          2'b11: begin
            core_gnt_o = 1'b1;
            state_d    = WAIT_B;
          end
          2'b10:   state_d = WAIT_W;
          2'b01:   state_d = WAIT_AW;
          default: state_d = WAIT_AW_W;
        endcase
      end

      // last W beat already gone
      WAIT_AW: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          core_gnt_o = 1'b1;
          state_d    = WAIT_B;
        end
      end

      WAIT_W: begin
        if (wr_done_i) begin
          core_gnt_o = 1'b1;
          state_d    = WAIT_B;
        end
      end

      WAIT_B: begin
        b_ready_o = 1'b1;
        if (b_valid_i) begin
          core_rsp_valid_o = 1'b1;
          core_rsp_o.err   = (b_i.resp != RESP_OKAY);
          state_d          = IDLE;
        end
      end

      WAIT_R: begin
        if (rd_done_i) begin
          state_d = DONE_READ;
        end
      end

      // buffer holds line, status and id of the finished burst
      DONE_READ: begin
        core_rsp_valid_o = 1'b1;
        core_rsp_o.rdata = line_i;
        core_rsp_o.id    = rd_id_i;
        core_rsp_o.err   = rd_err_i;
        state_d          = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_load) begin
      id_q <= core_req_i.id;
    end
  end

endmodule

// File: hdl/write_beat_sender.sv
`timescale 1ns/100ps

module write_beat_sender
  import adapter_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  line_t      wdata_i,
  input  line_strb_t be_i,
  input  req_kind_e  kind_i,
  output logic       w_valid_o,
  output axi_w_t     w_o,
  input  logic       w_ready_i,
  output logic       done_o
);

  beat_idx_t cnt_q;
  logic      busy_q;
  logic      last_beat;
  logic      beat_fire;

  // a single write is one beat and a line write ends on the top slot
  assign last_beat = (kind_i == REQ_SINGLE) || (cnt_q == LAST_BEAT_IDX);
  assign beat_fire = busy_q && w_ready_i;

  assign w_valid_o = busy_q;
  assign w_o.data  = wdata_i[cnt_q];
  assign w_o.strb  = be_i[cnt_q];
  assign w_o.last  = last_beat;
  assign done_o    = beat_fire && last_beat;

  // ------------------------------
  // beat counter
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (beat_fire) begin
      if (last_beat) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: hdl/line_fill_buffer.sv
`timescale 1ns/100ps

module line_fill_buffer
  import adapter_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start_i,
  input  req_kind_e kind_i,
  input  logic      r_valid_i,
  input  axi_r_t    r_i,
  output logic      r_ready_o,
  output line_t     line_o,
  output logic      done_o,
  output logic      err_o,
  output id_t       id_o
);

  logic      active_q;
  beat_idx_t cnt_q;
  logic      err_q;
  req_kind_e kind_q;
  id_t       id_q;
  line_t     line_q, line_d;
  logic      beat_fire;

  assign beat_fire = active_q && r_valid_i;

  assign r_ready_o = active_q;
  assign done_o    = beat_fire && r_i.last;
  assign err_o     = err_q;
  assign id_o      = id_q;
  assign line_o    = line_q;

  // ------------------------------
  // burst tracking
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
      err_q    <= 1'b0;
      kind_q   <= REQ_SINGLE;
    end else if (start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
      err_q    <= 1'b0;
      kind_q   <= kind_i;
    end else if (beat_fire) begin
      cnt_q <= cnt_q + 1'b1;
      // sticky over the whole burst
      err_q <= err_q || (r_i.resp != RESP_OKAY);
      if (r_i.last) begin
        active_q <= 1'b0;
      end
    end
  end

  // beats land in order and a single read fills only slot 0
  always_comb begin
    line_d = line_q;
    if (beat_fire) begin
      if (kind_q == REQ_LINE) begin
        line_d[cnt_q] = r_i.data;
      end else begin
        line_d    = '0;
        line_d[0] = r_i.data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    line_q <= line_d;
    if (beat_fire) begin
      id_q <= r_i.id;
    end
  end

endmodule

// File: hdl/axi_adapter.sv
`timescale 1ns/100ps

module axi_adapter
  import adapter_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // core side
  input  logic      core_req_valid_i,
  input  core_req_t core_req_i,
  output logic      core_gnt_o,
  output logic      core_rsp_valid_o,
  output core_rsp_t core_rsp_o,
  // read address
  output logic      ar_valid_o,
  output axi_ax_t   ar_o,
  input  logic      ar_ready_i,
  // write address
  output logic      aw_valid_o,
  output axi_ax_t   aw_o,
  input  logic      aw_ready_i,
  // write data
  output logic      w_valid_o,
  output axi_w_t    w_o,
  input  logic      w_ready_i,
  // read data
  input  logic      r_valid_i,
  input  axi_r_t    r_i,
  output logic      r_ready_o,
  // write response
  input  logic      b_valid_i,
  input  axi_b_t    b_i,
  output logic      b_ready_o
);

  logic      wr_start;
  logic      wr_done;
  logic      rd_start;
  req_kind_e rd_kind;
  logic      rd_done;
  logic      rd_err;
  id_t       rd_id;
  line_t     fill_line;

  adapter_ctrl u_adapter_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_req_valid_i (core_req_valid_i),
    .core_req_i       (core_req_i),
    .core_gnt_o       (core_gnt_o),
    .core_rsp_valid_o (core_rsp_valid_o),
    .core_rsp_o       (core_rsp_o),
    .ar_valid_o       (ar_valid_o),
    .ar_o             (ar_o),
    .ar_ready_i       (ar_ready_i),
    .aw_valid_o       (aw_valid_o),
    .aw_o             (aw_o),
    .aw_ready_i       (aw_ready_i),
    .b_valid_i        (b_valid_i),
    .b_i              (b_i),
    .b_ready_o        (b_ready_o),
    .wr_start_o       (wr_start),
    .wr_done_i        (wr_done),
    .rd_start_o       (rd_start),
    .rd_kind_o        (rd_kind),
    .rd_done_i        (rd_done),
    .rd_err_i         (rd_err),
    .rd_id_i          (rd_id),
    .line_i           (fill_line)
  );

  // write data comes from the held request until grant
  write_beat_sender u_write_beat_sender (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (wr_start),
    .wdata_i   (core_req_i.wdata),
    .be_i      (core_req_i.be),
    .kind_i    (core_req_i.kind),
    .w_valid_o (w_valid_o),
    .w_o       (w_o),
    .w_ready_i (w_ready_i),
    .done_o    (wr_done)
  );

  line_fill_buffer u_line_fill_buffer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (rd_start),
    .kind_i    (rd_kind),
    .r_valid_i (r_valid_i),
    .r_i       (r_i),
    .r_ready_o (r_ready_o),
    .line_o    (fill_line),
    .done_o    (rd_done),
    .err_o     (rd_err),
    .id_o      (rd_id)
  );

endmodule

// File: testbench/tb_axi_adapter_assert.sv
`timescale 1ns/100ps

module tb_axi_adapter_assert
  import adapter_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input core_req_t core_req_i,
  input logic      core_gnt_o,
  input logic      core_rsp_valid_o,
  input logic      ar_valid_o,
  input axi_ax_t   ar_o,
  input logic      ar_ready_i,
  input logic      aw_valid_o,
  input axi_ax_t   aw_o,
  input logic      aw_ready_i,
  input logic      w_valid_o,
  input axi_w_t    w_o,
  input logic      w_ready_i
);

  logic      granted_q;
  beat_idx_t wcnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      granted_q <= 1'b0;
      wcnt_q    <= '0;
    end else begin
      if (core_gnt_o) granted_q <= 1'b1;
      else if (core_rsp_valid_o) granted_q <= 1'b0;
      if (w_valid_o && w_ready_i) wcnt_q <= w_o.last ? '0 : wcnt_q + 1'b1;
    end
  end

  // ------------------------------
  // bus handshake rules
  // ------------------------------
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("AR dropped or changed before ready");

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else $error("AW dropped or changed before ready");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
    else $error("W dropped or changed before ready");

  rsp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_rsp_valid_o |-> granted_q)
    else $error("response without a grant");

  // last only on beat 0 of a single or beat 3 of a line
  w_last_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o |-> (w_o.last == (core_req_i.kind == REQ_SINGLE || wcnt_q == LAST_BEAT_IDX)))
    else $error("W last on the wrong beat");

endmodule

bind axi_adapter tb_axi_adapter_assert u_tb_axi_adapter_assert (.*);

// File: testbench/tb_axi_adapter.sv
`timescale 1ns/100ps

module tb_axi_adapter
  import adapter_pkg::*;
();

  localparam int MAX_OPS = 64;

  logic      clk_i;
  logic      rst_ni;
  logic      core_req_valid_i;
  core_req_t core_req_i;
  logic      core_gnt_o;
  logic      core_rsp_valid_o;
  core_rsp_t core_rsp_o;
  logic      ar_valid_o;
  axi_ax_t   ar_o;
  logic      ar_ready_i;
  logic      aw_valid_o;
  axi_ax_t   aw_o;
  logic      aw_ready_i;
  logic      w_valid_o;
  axi_w_t    w_o;
  logic      w_ready_i;
  logic      r_valid_i;
  axi_r_t    r_i;
  logic      r_ready_o;
  logic      b_valid_i;
  axi_b_t    b_i;
  logic      b_ready_o;

  axi_adapter u_axi_adapter (.*);

  // golden operations
  int         n_ops;
  int         op_kind [MAX_OPS];
  int         op_we [MAX_OPS];
  id_t        op_id [MAX_OPS];
  addr_t      op_addr [MAX_OPS];
  line_t      op_wdata [MAX_OPS];
  line_strb_t op_be [MAX_OPS];
  line_t      exp_rdata [MAX_OPS];
  int         exp_err [MAX_OPS];
  int         cur_op;

  int          value_errors;
  int          proto_errors;
  int          cycles;
  int          cycle_limit;
  logic [31:0] lfsr_q;

  // slave model state
  line_t   mem [256];
  axi_ax_t rd_q[$];
  axi_ax_t aw_q[$];
  axi_w_t  w_q[$];
  axi_b_t  b_q[$];
  axi_ax_t cur_rd;
  logic    rd_busy;
  int      rd_beat;
  logic    slave_en;
  logic    ar_fire, aw_fire, w_fire, r_fire, b_fire;
  axi_ax_t ar_s, aw_s;
  axi_w_t  w_s;

  always #4 clk_i = ~clk_i;

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // address phase of operation n
  function automatic axi_ax_t expected_ax(input int n);
    axi_ax_t ax;
    ax.addr = op_addr[n];
    ax.id   = op_id[n];
    ax.len  = 8'd0;
    ax.size = 3'd3;
    if (op_kind[n] != 0) begin
      // a line burst starts on the line boundary
      ax.addr = op_addr[n] & ~addr_t'(BEATS_PER_LINE * STRB_WIDTH - 1);
      ax.len  = 8'(BEATS_PER_LINE - 1);
    end
    return ax;
  endfunction

  task automatic check_line(input line_t exp, input line_t got);
    if (exp !== got) begin
      $display("error core_rsp rdata exp %h got %h", exp, got);
      value_errors++;
    end
  endtask

  task automatic check_id(input id_t exp, input id_t got);
    if (exp !== got) begin
      $display("error core_rsp id exp %h got %h", exp, got);
      value_errors++;
    end
  endtask

  task automatic check_err(input logic exp, input logic got);
    if (exp !== got) begin
      $display("error core_rsp err exp %h got %h", exp, got);
      value_errors++;
    end
  endtask

  task automatic check_ax(input string chan, input axi_ax_t exp, input axi_ax_t got);
    if (exp !== got) begin
      $display("error %s exp %h got %h", chan, exp, got);
      value_errors++;
    end
  endtask

  task automatic check_ctrl_low();
    if (core_gnt_o || core_rsp_valid_o || ar_valid_o || aw_valid_o || w_valid_o ||
        r_ready_o || b_ready_o) begin
      $display("a control output is high right after reset");
      proto_errors++;
    end
  endtask

  task automatic load_golden();
    int    fd;
    int    k, we, e;
    string text;
    fd = $fopen("testbench/adapter_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file");
      proto_errors++;
      return;
    end
    while (!$feof(fd) && n_ops < MAX_OPS) begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() > 0 && text.getc(0) != 8'h23) begin
        if ($sscanf(text, "%d %d %h %h %h %h %h %d", k, we, op_id[n_ops], op_addr[n_ops],
                    op_wdata[n_ops], op_be[n_ops], exp_rdata[n_ops], e) == 8) begin
          op_kind[n_ops] = k;
          op_we[n_ops]   = we;
          exp_err[n_ops] = e;
          n_ops++;
        end
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------
  // memory slave
  // ------------------------------
  task automatic complete_write();
    axi_ax_t aw;
    logic    err;
    int      idx;
    if (aw_q.size() > 0 && w_q.size() > 0 && w_q[w_q.size()-1].last) begin
      aw  = aw_q.pop_front();
      err = aw.addr[31];
      idx = aw.addr[12:5];
      for (int i = 0; i < w_q.size(); i++) begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (!err && w_q[i].strb[b]) mem[idx][i][8*b +: 8] = w_q[i].data[8*b +: 8];
        end
      end
      w_q.delete();
      b_q.push_back(axi_b_t'{id: aw.id, resp: err ? RESP_SLVERR : RESP_OKAY});
    end
  endtask

  always begin
    @(negedge clk_i);
    if (slave_en) begin
      if (ar_fire) begin
        check_ax("ar_o", expected_ax(cur_op), ar_s);
        rd_q.push_back(ar_s);
      end
      if (aw_fire) begin
        check_ax("aw_o", expected_ax(cur_op), aw_s);
        aw_q.push_back(aw_s);
      end
      if (w_fire) w_q.push_back(w_s);
      if (r_fire) begin
        r_valid_i = 1'b0;
        rd_beat++;
        if (r_i.last) rd_busy = 1'b0;
      end
      if (b_fire) b_valid_i = 1'b0;
      complete_write();
      if (!rd_busy && rd_q.size() > 0) begin
        cur_rd  = rd_q.pop_front();
        rd_busy = 1'b1;
        rd_beat = 0;
      end
      ar_ready_i = next_bit();
      aw_ready_i = next_bit();
      w_ready_i  = next_bit();
      if (rd_busy && !r_valid_i && next_bit()) begin
        r_valid_i = 1'b1;
        r_i.id    = cur_rd.id;
        r_i.resp  = cur_rd.addr[31] ? RESP_SLVERR : RESP_OKAY;
        r_i.data  = cur_rd.addr[31] ? '0 : mem[cur_rd.addr[12:5]][rd_beat];
        r_i.last  = (rd_beat == cur_rd.len);
      end
      if (!b_valid_i && b_q.size() > 0 && next_bit()) begin
        b_valid_i = 1'b1;
        b_i       = b_q.pop_front();
      end
    end
    // transfers that the next rising edge will take
    #1;
    slave_en = rst_ni;
    ar_fire  = ar_valid_o && ar_ready_i;
    aw_fire  = aw_valid_o && aw_ready_i;
    w_fire   = w_valid_o && w_ready_i;
    r_fire   = r_valid_i && r_ready_o;
    b_fire   = b_valid_i && b_ready_o;
    ar_s     = ar_o;
    aw_s     = aw_o;
    w_s      = w_o;
  end

  // ------------------------------
  // core side
  // ------------------------------
  task automatic run_op(input int n);
    logic got_gnt;
    logic got_rsp;
    got_gnt = 1'b0;
    got_rsp = 1'b0;
    @(negedge clk_i);
    cur_op           = n;
    core_req_i.kind  = op_kind[n] ? REQ_LINE : REQ_SINGLE;
    core_req_i.we    = op_we[n][0];
    core_req_i.addr  = op_addr[n];
    core_req_i.id    = op_id[n];
    core_req_i.size  = 3'd3;
    core_req_i.wdata = op_wdata[n];
    core_req_i.be    = op_be[n];
    core_req_valid_i = 1'b1;
    while (!got_rsp) begin
      #1;
      if (core_rsp_valid_o) begin
        if (!got_gnt) begin
          $display("response arrived before the grant in operation %0d", n);
          proto_errors++;
        end
        got_rsp = 1'b1;
        check_line(exp_rdata[n], core_rsp_o.rdata);
        check_id(op_id[n], core_rsp_o.id);
        check_err(exp_err[n][0], core_rsp_o.err);
      end
      if (core_gnt_o) begin
        if (got_gnt) begin
          $display("request %0d was granted twice", n);
          proto_errors++;
        end
        got_gnt = 1'b1;
      end
      @(negedge clk_i);
      if (got_gnt) core_req_valid_i = 1'b0;
    end
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    core_req_valid_i = 1'b0;
    core_req_i = '0;
    ar_ready_i = 1'b0;
    aw_ready_i = 1'b0;
    w_ready_i = 1'b0;
    r_valid_i = 1'b0;
    r_i = '0;
    b_valid_i = 1'b0;
    b_i = '0;
    lfsr_q = 32'hf5d6_8b24;
    rd_busy = 1'b0;
    rd_beat = 0;
    slave_en = 1'b0;
    cur_op = 0;
    {ar_fire, aw_fire, w_fire, r_fire, b_fire} = '0;
    for (int i = 0; i < 256; i++) mem[i] = '0;
    load_golden();
    cycle_limit = n_ops * 64 + 16;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_ctrl_low();
    for (int n = 0; n < n_ops; n++) run_op(n);
    $display("errors: %0d value, %0d protocol, %0d operations", value_errors, proto_errors,
             n_ops);
    if (value_errors == 0 && proto_errors == 0 && n_ops > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: testbench/adapter_golden.txt
# kind(0 single 1 line) we id addr wdata(beat3..beat0) be(beat3..beat0) exp_rdata exp_err
# memory starts zero, bit 31 of addr gives SLVERR
1 1 1 00000100 13579bdf02468ace0123456789abcdeffedcba9876543210a5a5a5a55a5a5a5a ffffffff 0000000000000000000000000000000000000000000000000000000000000000 0
1 0 2 00000100 0000000000000000000000000000000000000000000000000000000000000000 00000000 13579bdf02468ace0123456789abcdeffedcba9876543210a5a5a5a55a5a5a5a 0
0 1 3 00000100 0000000000000000000000000000000000000000000000001111222233334444 0000000f 0000000000000000000000000000000000000000000000000000000000000000 0
1 0 4 00000100 0000000000000000000000000000000000000000000000000000000000000000 00000000 13579bdf02468ace0123456789abcdeffedcba9876543210a5a5a5a533334444 0
1 0 5 00000118 0000000000000000000000000000000000000000000000000000000000000000 00000000 13579bdf02468ace0123456789abcdeffedcba9876543210a5a5a5a533334444 0
0 0 6 00000108 0000000000000000000000000000000000000000000000000000000000000000 00000000 000000000000000000000000000000000000000000000000a5a5a5a533334444 0
1 1 7 80000100 cafef00d00000003cafef00d00000002cafef00d00000001cafef00d00000000 ffffffff 0000000000000000000000000000000000000000000000000000000000000000 1
1 0 8 80000200 0000000000000000000000000000000000000000000000000000000000000000 00000000 0000000000000000000000000000000000000000000000000000000000000000 1
1 0 9 00000100 0000000000000000000000000000000000000000000000000000000000000000 00000000 13579bdf02468ace0123456789abcdeffedcba9876543210a5a5a5a533334444 0
1 1 a 00000200 cafef00d00000003cafef00d00000002cafef00d00000001cafef00d00000000 ffffffff 0000000000000000000000000000000000000000000000000000000000000000 0
1 0 b 00000200 0000000000000000000000000000000000000000000000000000000000000000 00000000 cafef00d00000003cafef00d00000002cafef00d00000001cafef00d00000000 0
0 0 c 00000300 0000000000000000000000000000000000000000000000000000000000000000 00000000 0000000000000000000000000000000000000000000000000000000000000000 0
0 1 d 80000300 00000000000000000000000000000000000000000000000000000000deadbeef 000000ff 0000000000000000000000000000000000000000000000000000000000000000 1
0 0 e 00000300 0000000000000000000000000000000000000000000000000000000000000000 00000000 0000000000000000000000000000000000000000000000000000000000000000 0
0 1 f 00000300 00000000000000000000000000000000000000000000000000000000deadbeef 000000ff 0000000000000000000000000000000000000000000000000000000000000000 0
0 0 1 00000300 0000000000000000000000000000000000000000000000000000000000000000 00000000 00000000000000000000000000000000000000000000000000000000deadbeef 0

// File: tb.f
common/adapter_pkg.sv
hdl/adapter_ctrl.sv
hdl/write_beat_sender.sv
hdl/line_fill_buffer.sv
hdl/axi_adapter.sv
testbench/tb_axi_adapter_assert.sv
testbench/tb_axi_adapter.sv

// File: Makefile
# Verilator flow for the AXI adapter testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_adapter
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := Test failures found

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
